//--- hdl/cpu_cfg.svh
/*
 * core widths and depths
 * CPU_PC_W and CPU_GHR_W must stay equal: the predictor index is pc ^ history.
 * CPU_IMEM_DEPTH must be 2**CPU_PC_W so every pc value addresses a word.
 */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word address of the instruction memory
`define CPU_PC_W        8
`define CPU_IMEM_DEPTH  256

`define CPU_REG_N       16

// global history length, also the counter table index width
`define CPU_GHR_W       8

// misprediction counter wraps at this width
`define CPU_CNT_W       16

`endif

//--- hdl/isa_pkg.sv
/*
 * instruction set of the core
 * opcodes outside the enum decode as NOP; immediates are 16-bit signed.
 */
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0] reg_addr_t;
    typedef logic signed [15:0] imm_t;

    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        ADDI = 4'd3,
        BNE  = 4'd4,
        OUT  = 4'd5,
        HALT = 4'd15
    } opcode_e;

    // opcode in the top nibble, immediate in the low half
    typedef struct packed {
        opcode_e   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t      imm;
    } instr_t;

endpackage

//--- hdl/pipe_pkg.sv
/*
 * pipeline control types
 * branch targets wrap to CPU_PC_W bits.
 */
`include "cpu_cfg.svh"

package pipe_pkg;

    typedef logic [`CPU_PC_W-1:0] pc_t;
    typedef logic [`CPU_GHR_W-1:0] ghr_t;
    typedef logic [`CPU_CNT_W-1:0] mispredict_cnt_t;

    typedef enum logic [1:0] {
        STRONG_NT = 2'd0,
        WEAK_NT   = 2'd1,
        WEAK_T    = 2'd2,
        STRONG_T  = 2'd3
    } sat_cnt_e;

    typedef enum logic {
        RUN    = 1'b0,
        HALTED = 1'b1
    } run_state_e;

    // taken target of a BNE at pc, used by both fetch and execute
    function automatic pc_t branch_target(pc_t pc, isa_pkg::imm_t imm);
        return pc + pc_t'(1) + pc_t'(imm);
    endfunction

endpackage

//--- hdl/pipe_if.sv
/*
 * bundles between the pipeline stages
 * fe_if is the fetch/execute register; resolve_if is combinational from execute.
 */
`timescale 1ns/1ps

interface fe_if
    import isa_pkg::*, pipe_pkg::*;
();
    logic   valid;
    pc_t    pc;
    instr_t instr;
    logic   predicted_taken;
    // history index used for the prediction, returned for training
    ghr_t   bht_index;

    modport fetch (output valid, pc, instr, predicted_taken, bht_index);
    modport exec  (input valid, pc, instr, predicted_taken, bht_index);
endinterface

interface resolve_if
    import pipe_pkg::*;
();
    logic resolved;
    logic taken;
    ghr_t bht_index;
    logic mispredict;
    // correct next pc of the resolved branch
    pc_t  target;

    modport exec      (output resolved, taken, bht_index, mispredict, target);
    modport fetch     (input mispredict, target);
    modport predictor (input resolved, taken, bht_index);
    modport ctrl      (input mispredict);
endinterface

//--- hdl/pipe_ctrl.sv
/*
 * stall, flush and halt control
 * tx_full is the only back-pressure; an OUT waiting on it holds the whole pipe.
 * after HALT the core stays stopped until rstn.
 */
`timescale 1ns/1ps

module pipe_ctrl
    import pipe_pkg::*;
(
    input  logic            clk,
    input  logic            rstn,
    input  logic            out_pending,
    input  logic            halt_seen,
    input  logic            tx_full,
    resolve_if.ctrl         res,
    output logic            advance,
    output logic            flush,
    output logic            tx_wr_en,
    output logic            halted,
    output mispredict_cnt_t mispredict_count
);

    run_state_e state;
    run_state_e state_next;

    always_comb begin
        state_next = state;
        case (state)
            RUN: begin
                if (halt_seen && advance) begin
                    state_next = HALTED;
                end
            end
            default: state_next = HALTED;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

    assign advance  = (state == RUN) && !(out_pending && tx_full);
    assign flush    = res.mispredict && advance;
    assign tx_wr_en = out_pending && advance;
    assign halted   = (state == HALTED);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            mispredict_count <= '0;
        end else if (flush) begin
            mispredict_count <= mispredict_count + mispredict_cnt_t'(1);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks

    // an OUT blocked by tx_full stays in execute until it is written
    tx_full_holds_out: assert property (
        @(posedge clk) disable iff (!rstn) out_pending && tx_full |=> out_pending
    );

    // halted only drops on the edge after a reset
    halted_sticky: assert property (
        @(posedge clk) $fell(halted) |-> $past(!rstn)
    );

endmodule

//--- hdl/gshare_predictor.sv
/*
 * gshare branch predictor
 * history holds resolved outcomes only, shifted when a BNE leaves execute.
 * the table is trained at the index carried with the branch, not recomputed.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module gshare_predictor
    import pipe_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    input  pc_t           pc,
    input  logic          advance,
    resolve_if.predictor  res,
    output logic          prediction,
    output ghr_t          index
);

    localparam int TABLE_N = 2 ** `CPU_GHR_W;

    ghr_t     ghr;
    sat_cnt_e cnt_tab [TABLE_N];

    // one saturating step toward the outcome
    function automatic sat_cnt_e cnt_step(sat_cnt_e cnt, logic taken);
        sat_cnt_e nxt;
        nxt = cnt;
        case (cnt)
            STRONG_NT: nxt = taken ? WEAK_NT : STRONG_NT;
            WEAK_NT:   nxt = taken ? WEAK_T : STRONG_NT;
            WEAK_T:    nxt = taken ? STRONG_T : WEAK_NT;
            STRONG_T:  nxt = taken ? STRONG_T : WEAK_T;
            default:   nxt = WEAK_NT;
        endcase
        return nxt;
    endfunction

    assign index      = ghr_t'(pc) ^ ghr;
    assign prediction = (cnt_tab[index] == WEAK_T) || (cnt_tab[index] == STRONG_T);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ghr <= '0;
            for (int i = 0; i < TABLE_N; i++) begin
                cnt_tab[i] <= WEAK_NT;
            end
        end else if (advance && res.resolved) begin
            ghr <= {ghr[`CPU_GHR_W-2:0], res.taken};
            cnt_tab[res.bht_index] <= cnt_step(cnt_tab[res.bht_index], res.taken);
        end
    end

endmodule

//--- hdl/fetch_unit.sv
/*
 * fetch stage with the instruction memory
 * the memory reads combinationally and may be written at any time, also in reset;
 * its contents survive reset. only BNE is predecoded for prediction.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module fetch_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      advance,
    input  logic      flush,
    input  logic      imem_we,
    input  pc_t       imem_waddr,
    input  word_t     imem_wdata,
    input  logic      prediction,
    input  ghr_t      index,
    output pc_t       pc,
    fe_if.fetch       fe,
    resolve_if.fetch  res
);

    word_t  imem [`CPU_IMEM_DEPTH];
    instr_t fetch_instr;
    logic   pred_taken;
    pc_t    next_pc;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_waddr] <= imem_wdata;
        end
    end

    assign fetch_instr = instr_t'(imem[pc]);
    assign pred_taken  = (fetch_instr.opcode == BNE) && prediction;

    // a mispredict in execute overrides this cycle's own prediction
    always_comb begin
        if (res.mispredict) begin
            next_pc = res.target;
        end else if (pred_taken) begin
            next_pc = branch_target(pc, fetch_instr.imm);
        end else begin
            next_pc = pc + pc_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc <= '0;
        end else if (advance) begin
            pc <= next_pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // fetch/execute register

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fe.valid <= 1'b0;
        end else if (advance) begin
            fe.valid <= !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            fe.pc              <= pc;
            fe.instr           <= fetch_instr;
            fe.predicted_taken <= pred_taken;
            fe.bht_index       <= index;
        end
    end

endmodule

//--- hdl/exec_unit.sv
/*
 * execute stage and writeback register
 * only the writeback result is forwarded, which covers every hazard here.
 * BNE resolves in this stage; its taken target wraps to the pc width.
 */
`timescale 1ns/1ps

module exec_unit
    import isa_pkg::*, pipe_pkg::*;
(
    input  logic         clk,
    input  logic         rstn,
    input  logic         advance,
    fe_if.exec           fe,
    resolve_if.exec      res,
    output reg_addr_t    rs1_addr,
    output reg_addr_t    rs2_addr,
    input  word_t        rs1_data,
    input  word_t        rs2_data,
    output logic         wb_we,
    output reg_addr_t    wb_addr,
    output word_t        wb_data,
    output logic         out_pending,
    output logic         halt_seen,
    output logic [7:0]   tx_data
);

    instr_t ins;
    word_t  src1;
    word_t  src2;
    word_t  alu_result;
    logic   writes_rd;
    logic   fwd1;
    logic   fwd2;

    assign ins      = fe.instr;
    assign rs1_addr = ins.rs1;
    assign rs2_addr = ins.rs2;

    // r0 never forwards, it always reads zero
    assign fwd1 = wb_we && (wb_addr == ins.rs1) && (wb_addr != '0);
    assign fwd2 = wb_we && (wb_addr == ins.rs2) && (wb_addr != '0);
    assign src1 = fwd1 ? wb_data : rs1_data;
    assign src2 = fwd2 ? wb_data : rs2_data;

    always_comb begin
        alu_result = '0;
        writes_rd  = 1'b0;
        if (fe.valid) begin
            case (ins.opcode)
                ADD: begin
                    alu_result = src1 + src2;
                    writes_rd  = 1'b1;
                end
                SUB: begin
                    alu_result = src1 - src2;
                    writes_rd  = 1'b1;
                end
                ADDI: begin
                    alu_result = src1 + {{16{ins.imm[15]}}, ins.imm};
                    writes_rd  = 1'b1;
                end
                default: ;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // branch resolution

    assign res.resolved   = fe.valid && (ins.opcode == BNE);
    assign res.taken      = (src1 != src2);
    assign res.bht_index  = fe.bht_index;
    assign res.mispredict = res.resolved && (res.taken != fe.predicted_taken);
    assign res.target     = res.taken ? branch_target(fe.pc, ins.imm) : fe.pc + pc_t'(1);

    assign out_pending = fe.valid && (ins.opcode == OUT);
    assign halt_seen   = fe.valid && (ins.opcode == HALT);
    assign tx_data     = src1[7:0];

    // writeback register
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_we <= 1'b0;
        end else if (advance) begin
            wb_we <= writes_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            wb_addr <= ins.rd;
            wb_data <= alu_result;
        end
    end

    // fetch redirects only on a BNE, so only a BNE arrives predicted taken
    predict_only_bne: assert property (
        @(posedge clk) disable iff (!rstn) fe.valid && fe.predicted_taken |-> ins.opcode == BNE
    );

    // a mispredict must leave a bubble behind it
    mispredict_bubble: assert property (
        @(posedge clk) disable iff (!rstn) res.mispredict && advance |=> !fe.valid
    );

endmodule

//--- hdl/reg_file.sv
/*
 * integer register file, two reads and one write
 * r0 reads zero and ignores writes. contents are not cleared by reset.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module reg_file
    import isa_pkg::*;
(
    input  logic      clk,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t wb_addr,
    input  logic      wb_we,
    input  word_t     wb_data,
    output word_t     rs1_data,
    output word_t     rs2_data
);

    word_t regs [`CPU_REG_N];

    always_ff @(posedge clk) begin
        if (wb_we && (wb_addr != '0)) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // write lands at the edge, execute sees it earlier through forwarding
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

//--- hdl/cpu_top.sv
/*
 * three-stage core: fetch, execute, writeback
 * load the program through imem_we before releasing rstn.
 * one byte leaves on each cycle tx_wr_en is high; halted ends the run.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 imem_we,
    input  logic [`CPU_PC_W-1:0] imem_waddr,
    input  logic [31:0]          imem_wdata,
    output logic [7:0]           tx_data,
    output logic                 tx_wr_en,
    input  logic                 tx_full,
    output logic                 halted,
    output logic [`CPU_CNT_W-1:0] mispredict_count
);

    logic               advance;
    logic               flush;
    logic               out_pending;
    logic               halt_seen;
    logic               prediction;
    pipe_pkg::ghr_t     index;
    pipe_pkg::pc_t      pc;
    isa_pkg::reg_addr_t rs1_addr;
    isa_pkg::reg_addr_t rs2_addr;
    isa_pkg::word_t     rs1_data;
    isa_pkg::word_t     rs2_data;
    logic               wb_we;
    isa_pkg::reg_addr_t wb_addr;
    isa_pkg::word_t     wb_data;

    fe_if      fe_bus ();
    resolve_if res_bus ();

    pipe_ctrl pipe_ctrl_i (
        .clk              (clk),
        .rstn             (rstn),
        .out_pending      (out_pending),
        .halt_seen        (halt_seen),
        .tx_full          (tx_full),
        .res              (res_bus.ctrl),
        .advance          (advance),
        .flush            (flush),
        .tx_wr_en         (tx_wr_en),
        .halted           (halted),
        .mispredict_count (mispredict_count)
    );

    gshare_predictor gshare_predictor_i (
        .clk        (clk),
        .rstn       (rstn),
        .pc         (pc),
        .advance    (advance),
        .res        (res_bus.predictor),
        .prediction (prediction),
        .index      (index)
    );

    fetch_unit fetch_unit_i (
        .clk        (clk),
        .rstn       (rstn),
        .advance    (advance),
        .flush      (flush),
        .imem_we    (imem_we),
        .imem_waddr (imem_waddr),
        .imem_wdata (imem_wdata),
        .prediction (prediction),
        .index      (index),
        .pc         (pc),
        .fe         (fe_bus.fetch),
        .res        (res_bus.fetch)
    );

    exec_unit exec_unit_i (
        .clk         (clk),
        .rstn        (rstn),
        .advance     (advance),
        .fe          (fe_bus.exec),
        .res         (res_bus.exec),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .out_pending (out_pending),
        .halt_seen   (halt_seen),
        .tx_data     (tx_data)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb_addr  (wb_addr),
        .wb_we    (wb_we),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

endmodule

//--- dv/tb_cpu.sv
/*
 * testbench for the three-stage core
 * each test loads its program in reset, then runs it until halted.
 * the register file has no reset, so every program sets what it reads.
 * unused instruction words are filled with HALT.
 */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 8;
    localparam int NUM_TESTS       = 5;
    localparam int PROG_MAX        = 16;
    localparam int EXP_MAX         = 40;
    localparam int IMEM_WORDS      = 256;
    localparam int POST_HALT       = 20;
    localparam int MID_RESET_BYTES = 10;
    localparam int WATCHDOG_NS     = NUM_TESTS * 3000 * CLK_PERIOD;

    localparam logic [3:0] OP_ADD  = 4'd1;
    localparam logic [3:0] OP_SUB  = 4'd2;
    localparam logic [3:0] OP_ADDI = 4'd3;
    localparam logic [3:0] OP_BNE  = 4'd4;
    localparam logic [3:0] OP_OUT  = 4'd5;
    localparam logic [3:0] OP_HALT = 4'd15;

    logic                  clk;
    logic                  rstn;
    logic                  imem_we;
    logic [`CPU_PC_W-1:0]  imem_waddr;
    logic [31:0]           imem_wdata;
    logic [7:0]            tx_data;
    logic                  tx_wr_en;
    logic                  tx_full;
    logic                  halted;
    logic [`CPU_CNT_W-1:0] mispredict_count;

    // stimulus table, one entry per test
    string       test_name [NUM_TESTS];
    logic [31:0] prog_tab  [NUM_TESTS][PROG_MAX];
    int          prog_len  [NUM_TESTS];
    logic [7:0]  exp_tab   [NUM_TESTS][EXP_MAX];
    int          exp_len   [NUM_TESTS];
    logic        bp_tab    [NUM_TESTS];
    logic        reset_mid [NUM_TESTS];
    int          mp_min    [NUM_TESTS];
    int          mp_max    [NUM_TESTS];

    logic [7:0] got_q [$];
    integer     seed;
    int         errors;
    int         tests_failed;

    cpu_top cpu_top_i (
        .clk              (clk),
        .rstn             (rstn),
        .imem_we          (imem_we),
        .imem_waddr       (imem_waddr),
        .imem_wdata       (imem_wdata),
        .tx_data          (tx_data),
        .tx_wr_en         (tx_wr_en),
        .tx_full          (tx_full),
        .halted           (halted),
        .mispredict_count (mispredict_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the core never reached halted");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // a byte leaves on every edge with tx_wr_en high
    always @(posedge clk) begin
        if (tx_wr_en === 1'b1) begin
            got_q.push_back(tx_data);
            if (tx_full === 1'b1) begin
                $display("tx_wr_en was high while tx_full was high");
                errors++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // program table

    function automatic logic [31:0] encode(logic [3:0] op, int rd, int rs1, int rs2, int imm);
        return {op, rd[3:0], rs1[3:0], rs2[3:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] filler_word(int a);
        return {OP_HALT, 12'h000, 8'h00, a[7:0]};
    endfunction

    // countdown from 40, one OUT per pass, exit through BNE
    task automatic set_countdown_entry(input int t);
        prog_tab[t][0] = encode(OP_ADDI, 1, 0, 0, 40);
        prog_tab[t][1] = encode(OP_OUT, 0, 1, 0, 0);
        prog_tab[t][2] = encode(OP_ADDI, 1, 1, 0, -1);
        prog_tab[t][3] = encode(OP_BNE, 0, 1, 0, -3);
        prog_tab[t][4] = encode(OP_HALT, 0, 0, 0, 0);
        prog_len[t] = 5;
        for (int i = 0; i < EXP_MAX; i++) begin
            exp_tab[t][i] = 8'(40 - i);
        end
        exp_len[t] = 40;
        mp_min[t] = 1;
        mp_max[t] = 12;
    endtask

    task automatic build_table();
        test_name[0] = "arithmetic with forwarding";
        prog_tab[0][0]  = encode(OP_ADDI, 1, 0, 0, 5);
        prog_tab[0][1]  = encode(OP_ADDI, 2, 1, 0, 7);
        prog_tab[0][2]  = encode(OP_ADD, 3, 1, 2, 0);
        prog_tab[0][3]  = encode(OP_SUB, 4, 3, 1, 0);
        prog_tab[0][4]  = encode(OP_ADDI, 5, 4, 0, -20);
        prog_tab[0][5]  = encode(OP_OUT, 0, 1, 0, 0);
        prog_tab[0][6]  = encode(OP_OUT, 0, 2, 0, 0);
        prog_tab[0][7]  = encode(OP_OUT, 0, 3, 0, 0);
        prog_tab[0][8]  = encode(OP_OUT, 0, 4, 0, 0);
        prog_tab[0][9]  = encode(OP_OUT, 0, 5, 0, 0);
        prog_tab[0][10] = encode(OP_SUB, 6, 5, 3, 0);
        prog_tab[0][11] = encode(OP_OUT, 0, 6, 0, 0);
        prog_tab[0][12] = encode(OP_ADDI, 7, 0, 0, 16'h1234);
        prog_tab[0][13] = encode(OP_ADD, 8, 7, 7, 0);
        prog_tab[0][14] = encode(OP_OUT, 0, 8, 0, 0);
        prog_tab[0][15] = encode(OP_HALT, 0, 0, 0, 0);
        prog_len[0] = 16;
        exp_tab[0][0] = 8'h05;
        exp_tab[0][1] = 8'h0c;
        exp_tab[0][2] = 8'h11;
        exp_tab[0][3] = 8'h0c;
        exp_tab[0][4] = 8'hf8;
        exp_tab[0][5] = 8'he7;
        exp_tab[0][6] = 8'h68;
        exp_len[0] = 7;
        mp_min[0] = 0;
        mp_max[0] = 0;

        test_name[1] = "loop and branch prediction";
        set_countdown_entry(1);
        test_name[2] = "back-pressure";
        set_countdown_entry(2);

        // r0 write is dropped, the OUT after HALT must never run
        test_name[3] = "halt and r0";
        prog_tab[3][0] = encode(OP_ADDI, 0, 0, 0, 16'h55);
        prog_tab[3][1] = encode(OP_OUT, 0, 0, 0, 0);
        prog_tab[3][2] = encode(OP_HALT, 0, 0, 0, 0);
        prog_tab[3][3] = encode(OP_ADDI, 3, 0, 0, 16'h77);
        prog_tab[3][4] = encode(OP_OUT, 0, 3, 0, 0);
        prog_tab[3][5] = encode(OP_HALT, 0, 0, 0, 0);
        prog_len[3] = 6;
        exp_tab[3][0] = 8'h00;
        exp_len[3] = 1;
        mp_min[3] = 0;
        mp_max[3] = 0;

        test_name[4] = "reset mid-run";
        set_countdown_entry(4);

        for (int t = 0; t < NUM_TESTS; t++) begin
            bp_tab[t] = (t == 2);
            reset_mid[t] = (t == 4);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // test sequence

    task automatic hold_reset();
        repeat (RESET_CYCLES) @(negedge clk);
        if (halted !== 1'b0) begin
            $display("Error: halted in reset got %h expected 0", halted);
            errors++;
        end
        if (mispredict_count !== '0) begin
            $display("Error: mispredict_count in reset got %h expected 0", mispredict_count);
            errors++;
        end
        got_q.delete();
    endtask

    task automatic run_entry(input int t);
        int          errs_start;
        int          n;
        logic [31:0] rnd;
        errs_start = errors;
        rstn = 1'b0;
        tx_full = 1'b0;
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem_we    = 1'b1;
            imem_waddr = a[`CPU_PC_W-1:0];
            imem_wdata = (a < prog_len[t]) ? prog_tab[t][a] : filler_word(a);
            @(negedge clk);
        end
        imem_we = 1'b0;
        hold_reset();
        rstn = 1'b1;
        if (reset_mid[t]) begin
            while (got_q.size() < MID_RESET_BYTES) @(negedge clk);
            rstn = 1'b0;
            hold_reset();
            rstn = 1'b1;
        end
        while (halted !== 1'b1) begin
            rnd = $random(seed);
            tx_full = bp_tab[t] ? rnd[0] : 1'b0;
            @(negedge clk);
        end
        tx_full = 1'b0;
        repeat (POST_HALT) begin
            @(negedge clk);
            if (halted !== 1'b1) begin
                $display("halted fell without a reset");
                errors++;
            end
        end

        if (got_q.size() != exp_len[t]) begin
            $display("Error: tx_data byte count got %0h expected %0h", got_q.size(), exp_len[t]);
            errors++;
        end
        n = (got_q.size() < exp_len[t]) ? got_q.size() : exp_len[t];
        for (int i = 0; i < n; i++) begin
            if (got_q[i] !== exp_tab[t][i]) begin
                $display("Error: tx_data[%0d] got %02h expected %02h", i, got_q[i],
                         exp_tab[t][i]);
                errors++;
            end
        end
        if (int'(mispredict_count) < mp_min[t] || int'(mispredict_count) > mp_max[t]) begin
            $display("Error: mispredict_count got %04h expected %0h to %0h",
                     mispredict_count, mp_min[t], mp_max[t]);
            errors++;
        end
        if (errors != errs_start) begin
            tests_failed++;
        end
        $display("test %0d, %s: %s, %0d bytes, %0d mispredicts", t + 1, test_name[t],
                 (errors == errs_start) ? "ok" : "failed", got_q.size(), mispredict_count);
    endtask

    initial begin
        rstn = 1'b0;
        imem_we = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        tx_full = 1'b0;
        seed = 32'h7090a154;
        errors = 0;
        tests_failed = 0;
        build_table();
        @(negedge clk);
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_entry(t);
        end
        $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS,
                 NUM_TESTS - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/pipe_if.sv
hdl/pipe_ctrl.sv
hdl/gshare_predictor.sv
hdl/fetch_unit.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/cpu_top.sv
dv/tb_cpu.sv

//--- Makefile
# Verilator build and run of the core testbench

.PHONY: all run clean

all: run

obj_dir/Vtb_cpu: sources.f $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)
	verilator --binary --timing --assert -f sources.f --top-module tb_cpu \
		-Mdir obj_dir -o Vtb_cpu

# the run fails unless the pass line shows up in the output
run: obj_dir/Vtb_cpu
	@out="$$(./obj_dir/Vtb_cpu)"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir
